// File: Bender.yml
package:
  name: ntm_writing

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/ntm_pkg.sv
      - source/ntm_vector_multiplier.sv
      - source/ntm_vector_adder.sv
      - source/ntm_writing.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/ntm_clock_gen.sv
      - testbench/ntm_writing_checker.sv
      - testbench/ntm_writing_tb.sv

// File: compile.f
+incdir+source
source/ntm_pkg.sv
source/ntm_vector_multiplier.sv
source/ntm_vector_adder.sv
source/ntm_writing.sv
testbench/ntm_clock_gen.sv
testbench/ntm_writing_checker.sv
testbench/ntm_writing_tb.sv

// File: source/ntm_cfg.svh
/*
 * NTM write head configuration
 * Element width, longest write vector and size counter width
 */

`ifndef NTM_CFG_SVH
`define NTM_CFG_SVH

// Element width in bits
`define NTM_DATA_SIZE 16

// Longest row the a buffer can hold
`define NTM_MAX_W 8

// Width of size inputs and row/column counters
`define NTM_SIZE_BITS 4

`endif

// File: source/ntm_pkg.sv
/*
 * NTM write head types
 * Controller states and adder opcodes
 */

`default_nettype none

package ntm_pkg;

  // Write head controller states
  typedef enum logic [2:0] {
    IDLE,
    LOAD_A,
    GET_W,
    STREAM_M,
    DRAIN,
    DONE
  } write_state_t;

  // Adder opcodes
  // Subtraction is the erase-style update
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1
  } adder_op_t;

endpackage

`default_nettype wire

// File: source/ntm_vector_adder.sv
/*
 * Streaming vector adder/subtractor
 * Combines a memory element with its product, one cycle latency,
 * result wraps to DATA_SIZE bits
 */

`default_nettype none

`include "ntm_cfg.svh"

module ntm_vector_adder
  import ntm_pkg::*;
#(
  parameter int DATA_SIZE = `NTM_DATA_SIZE
) (
  input  logic                 CLK,
  input  logic                 RST,

  // Operand strobe, opcode and data
  input  logic                 operand_enable,
  input  adder_op_t            operation,
  input  logic [DATA_SIZE-1:0] data_a_in,
  input  logic [DATA_SIZE-1:0] data_b_in,

  // Result
  output logic                 sum_enable,
  output logic [DATA_SIZE-1:0] sum
);

  ////////////////////////////////////////
  // Arithmetic
  ////////////////////////////////////////

  logic [DATA_SIZE-1:0] result;

  // Plain wrap, no carry or borrow kept
  always_comb begin
    case (operation)
      OP_SUB:  result = data_a_in - data_b_in;
      default: result = data_a_in + data_b_in;
    endcase
  end

  ////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////

  // Strobe follows operand_enable by one cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sum_enable <= 1'b0;
    end else begin
      sum_enable <= operand_enable;
    end
  end

  // Result only loads on a valid operand
  always_ff @(posedge CLK) begin
    if (operand_enable) begin
      sum <= result;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Opcode must be defined whenever an operand is taken
  a_legal_operation : assert property (
    @(posedge CLK) disable iff (RST)
    operand_enable |-> (operation inside {OP_ADD, OP_SUB})
  ) else $error("illegal adder opcode %0d", operation);

endmodule

`default_nettype wire

// File: source/ntm_vector_multiplier.sv
/*
 * Streaming vector multiplier
 * Scales each strobed element by a held scalar, one cycle latency,
 * product wraps to DATA_SIZE bits
 */

`default_nettype none

`include "ntm_cfg.svh"

module ntm_vector_multiplier #(
  parameter int DATA_SIZE = `NTM_DATA_SIZE
) (
  input  logic                 CLK,
  input  logic                 RST,

  // Operand strobe and data
  input  logic                 operand_enable,
  input  logic [DATA_SIZE-1:0] scalar_in,
  input  logic [DATA_SIZE-1:0] element_in,

  // Result
  output logic                 product_enable,
  output logic [DATA_SIZE-1:0] product
);

  ////////////////////////////////////////
  // Strobe pipeline
  ////////////////////////////////////////

  // One pulse out per operand strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      product_enable <= 1'b0;
    end else begin
      product_enable <= operand_enable;
    end
  end

  ////////////////////////////////////////
  // Product register
  ////////////////////////////////////////

  // Low half of the full product only
  always_ff @(posedge CLK) begin
    if (operand_enable) begin
      product <= DATA_SIZE'(scalar_in * element_in);
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Scalar and element must be loaded before a product is taken
  a_known_operands : assert property (
    @(posedge CLK) disable iff (RST)
    operand_enable |-> !$isunknown({scalar_in, element_in})
  ) else $error("operand strobe with unknown scalar or element");

endmodule

`default_nettype wire

// File: source/ntm_writing.sv
/*
 * NTM write head
 * Applies M(j,k) <= M(j,k) +/- w(j)*a(k) to a streamed memory,
 * buffering a and walking rows and columns, two cycle element latency
 */

`default_nettype none

`include "ntm_cfg.svh"

module ntm_writing
  import ntm_pkg::*;
(
  input  logic                         CLK,
  input  logic                         RST,

  // Run control
  input  logic                         start,
  input  adder_op_t                    write_op,
  input  logic [`NTM_SIZE_BITS-1:0]    size_n_in,
  input  logic [`NTM_SIZE_BITS-1:0]    size_w_in,

  // Element strobes
  input  logic                         a_in_enable,
  input  logic                         w_in_enable,
  input  logic                         m_in_enable,
  input  logic [`NTM_DATA_SIZE-1:0]    a_in,
  input  logic [`NTM_DATA_SIZE-1:0]    w_in,
  input  logic [`NTM_DATA_SIZE-1:0]    m_in,

  // Updated elements
  output logic                         m_out_enable,
  output logic [`NTM_DATA_SIZE-1:0]    m_out,

  // Done pulse
  output logic                         ready
);

  // Buffer index width
  localparam int IDX_BITS = $clog2(`NTM_MAX_W);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // FSM
  write_state_t state;

  // Run parameters latched at start
  adder_op_t                   op_reg;
  logic [`NTM_SIZE_BITS-1:0]   size_n_reg;
  logic [`NTM_SIZE_BITS-1:0]   size_w_reg;

  // Position in the matrix
  logic [`NTM_SIZE_BITS-1:0]   row_cnt;
  logic [`NTM_SIZE_BITS-1:0]   col_cnt;
  logic                        last_col;
  logic                        last_row;

  // Write vector and row weight
  logic [`NTM_DATA_SIZE-1:0]   a_buf [`NTM_MAX_W];
  logic [`NTM_DATA_SIZE-1:0]   w_reg;

  // Memory element aligned with its product
  logic [`NTM_DATA_SIZE-1:0]   m_dly;

  // Multiplier side
  logic                        mul_en;
  logic [`NTM_DATA_SIZE-1:0]   mul_element;
  logic                        prod_en;
  logic [`NTM_DATA_SIZE-1:0]   prod;

  // Outputs seen in this run
  logic [2*`NTM_SIZE_BITS-1:0] out_cnt;

  ////////////////////////////////////////
  // Counters and strobe decode
  ////////////////////////////////////////

  assign last_col = (col_cnt == size_w_reg - 1'b1);
  assign last_row = (row_cnt == size_n_reg - 1'b1);

  // Memory strobes count only while streaming a row
  assign mul_en = m_in_enable && (state == STREAM_M);

  // a(k) for the current column
  assign mul_element = a_buf[col_cnt[IDX_BITS-1:0]];

  // Done pulse straight from state
  assign ready = (state == DONE);

  ////////////////////////////////////////
  // Controller FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= IDLE;
      op_reg     <= OP_ADD;
      size_n_reg <= '0;
      size_w_reg <= '0;
      row_cnt    <= '0;
      col_cnt    <= '0;
    end else begin
      case (state)
        IDLE: begin
          // Latch run parameters
          if (start) begin
            op_reg     <= write_op;
            size_n_reg <= size_n_in;
            size_w_reg <= size_w_in;
            row_cnt    <= '0;
            col_cnt    <= '0;
            state      <= LOAD_A;
          end
        end

        LOAD_A: begin
          // Fill slots 0 .. size_w-1
          if (a_in_enable) begin
            if (last_col) begin
              col_cnt <= '0;
              state   <= GET_W;
            end else begin
              col_cnt <= col_cnt + 1'b1;
            end
          end
        end

        GET_W: begin
          // One weight per row
          if (w_in_enable) begin
            state <= STREAM_M;
          end
        end

        STREAM_M: begin
          if (mul_en) begin
            if (last_col) begin
              col_cnt <= '0;
              // Last row done, wait for the pipeline
              if (last_row) begin
                state <= DRAIN;
              end else begin
                row_cnt <= row_cnt + 1'b1;
                state   <= GET_W;
              end
            end else begin
              col_cnt <= col_cnt + 1'b1;
            end
          end
        end

        DRAIN: begin
          // Final output leaves with nothing behind it
          if (m_out_enable && !prod_en) begin
            state <= DONE;
          end
        end

        DONE: begin
          state <= IDLE;
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Output count per run, cleared when a run starts
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_cnt <= '0;
    end else if (start && (state == IDLE)) begin
      out_cnt <= '0;
    end else if (m_out_enable) begin
      out_cnt <= out_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Data registers
  ////////////////////////////////////////

  // a buffer write port
  always_ff @(posedge CLK) begin
    if (a_in_enable && (state == LOAD_A)) begin
      a_buf[col_cnt[IDX_BITS-1:0]] <= a_in;
    end
  end

  // Row weight, held for the whole row
  always_ff @(posedge CLK) begin
    if (w_in_enable && (state == GET_W)) begin
      w_reg <= w_in;
    end
  end

  // One stage delay so m meets w*a at the adder
  always_ff @(posedge CLK) begin
    if (mul_en) begin
      m_dly <= m_in;
    end
  end

  ////////////////////////////////////////
  // Arithmetic stages
  ////////////////////////////////////////

  // w(j) * a(k)
  ntm_vector_multiplier #(
    .DATA_SIZE(`NTM_DATA_SIZE)
  ) vector_multiplier (
    .CLK           (CLK),
    .RST           (RST),
    .operand_enable(mul_en),
    .scalar_in     (w_reg),
    .element_in    (mul_element),
    .product_enable(prod_en),
    .product       (prod)
  );

  // M +/- w*a, feeds the outputs directly
  ntm_vector_adder #(
    .DATA_SIZE(`NTM_DATA_SIZE)
  ) vector_adder (
    .CLK           (CLK),
    .RST           (RST),
    .operand_enable(prod_en),
    .operation     (op_reg),
    .data_a_in     (m_dly),
    .data_b_in     (prod),
    .sum_enable    (m_out_enable),
    .sum           (m_out)
  );

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Sizes must fit the buffer and be nonzero
  a_start_sizes : assert property (
    @(posedge CLK) disable iff (RST)
    (start && (state == IDLE)) |->
      (size_w_in != '0) && (size_w_in <= `NTM_MAX_W) && (size_n_in != '0)
  ) else $error("bad sizes at start n=%0d w=%0d", size_n_in, size_w_in);

  // Done only right after the last output of a full matrix
  a_ready_complete : assert property (
    @(posedge CLK) disable iff (RST)
    ready |-> $past(m_out_enable) && (out_cnt == size_n_reg * size_w_reg)
  ) else $error("ready before rows and columns complete");

endmodule

`default_nettype wire

// File: testbench/ntm_clock_gen.sv
/*
 * Testbench clock and reset
 * 100 ns clock, reset held high for four cycles
 */

`default_nettype none

module ntm_clock_gen (
  output logic CLK,
  output logic RST
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 4;

  // Free running, 50 ns per half period
  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // Clean rising edge so the async reset fires
  initial begin
    RST = 1'b0;
    #10 RST = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    // Release away from the active edge
    @(negedge CLK);
    RST = 1'b0;
  end

endmodule

`default_nettype wire

// File: testbench/ntm_writing_checker.sv
/*
 * Write head checker
 * Predicts each updated element from m, w and a, compares at m_out_enable,
 * checks latency, output count and the done pulse of every test
 */

`default_nettype none

`include "ntm_cfg.svh"

module ntm_writing_checker
  import ntm_pkg::*;
(
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      m_out_enable,
  input  logic [`NTM_DATA_SIZE-1:0] m_out,
  input  logic                      ready
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DS = `NTM_DATA_SIZE;

  // Expected elements and the cycle each one went in
  logic [DS-1:0] exp_q [$];
  int            tag_q [$];

  // Rising edge count, read by the driver at falling edges
  int cycle = 0;

  // Per test bookkeeping
  int out_count      = 0;
  int ready_count    = 0;
  int last_out_cycle = -1;
  int ready_cycle    = -1;
  int test_errors    = 0;

  // Run totals
  int tests_passed = 0;
  int tests_failed = 0;

  ////////////////////////////////////////
  // Prediction
  ////////////////////////////////////////

  // M +/- w*a, product cut to its low half, result wraps
  task automatic expect_element(input adder_op_t op, input logic [DS-1:0] m,
                                input logic [DS-1:0] w, input logic [DS-1:0] a);
    logic [2*DS-1:0] full;
    logic [DS-1:0]   prod;
    logic [DS-1:0]   exp_val;
    full = w * a;
    prod = full[DS-1:0];
    if (op == OP_SUB) begin
      exp_val = m - prod;
    end else begin
      exp_val = m + prod;
    end
    exp_q.push_back(exp_val);
    tag_q.push_back(cycle);
  endtask

  ////////////////////////////////////////
  // Output watch
  ////////////////////////////////////////

  // Sampled at the rising edge, values of the cycle just ended
  always @(posedge CLK) begin : watch
    logic [DS-1:0] exp_val;
    int            tag;
    if (RST) begin
      if (m_out_enable !== 1'b0 || ready !== 1'b0) begin
        $display("Output strobe or ready not low during reset");
        test_errors++;
      end
    end else begin
      if (m_out_enable === 1'b1) begin
        out_count++;
        last_out_cycle = cycle;
        if (exp_q.size() == 0) begin
          $display("Output strobe with no element pending, m_out=%h", m_out);
          test_errors++;
        end else begin
          exp_val = exp_q.pop_front();
          tag     = tag_q.pop_front();
          if (m_out !== exp_val) begin
            $display("Mismatch m_out expected %h got %h", exp_val, m_out);
            test_errors++;
          end
          // Two cycles from input strobe to output strobe
          if (cycle - tag != 2) begin
            $display("Output came %0d cycles after its input instead of 2", cycle - tag);
            test_errors++;
          end
        end
      end
      if (ready === 1'b1) begin
        ready_count++;
        ready_cycle = cycle;
      end
    end
    cycle++;
  end

  ////////////////////////////////////////
  // Test close
  ////////////////////////////////////////

  task automatic end_test(input int test_num, input int size_n, input int size_w);
    if (exp_q.size() != 0) begin
      $display("%0d outputs never arrived", exp_q.size());
      test_errors++;
    end
    if (out_count != size_n * size_w) begin
      $display("Got %0d outputs where %0d were due", out_count, size_n * size_w);
      test_errors++;
    end
    if (ready_count != 1) begin
      $display("ready pulsed %0d times instead of once", ready_count);
      test_errors++;
    end else if (ready_cycle != last_out_cycle + 1) begin
      $display("ready did not come one cycle after the last output");
      test_errors++;
    end
    if (test_errors == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("Test %0d n=%0d w=%0d outputs=%0d errors=%0d %s", test_num, size_n, size_w,
             out_count, test_errors, (test_errors == 0) ? "pass" : "FAIL");
    // Fresh counts for the next run
    exp_q.delete();
    tag_q.delete();
    out_count      = 0;
    ready_count    = 0;
    last_out_cycle = -1;
    ready_cycle    = -1;
    test_errors    = 0;
  endtask

endmodule

`default_nettype wire

// File: testbench/ntm_writing_tb.sv
/*
 * NTM write head testbench
 * Runs a table of write updates through the DUT with LCG data,
 * stray idle strobes and optional gaps between strobes
 */

`default_nettype none

`include "ntm_cfg.svh"

module ntm_writing_tb
  import ntm_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DS        = `NTM_DATA_SIZE;
  localparam int SB        = `NTM_SIZE_BITS;
  localparam int NUM_TESTS = 6;

  ////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////

  // Full size add and subtract, then gapped runs down to 1x1
  adder_op_t tbl_op   [NUM_TESTS] = '{OP_ADD, OP_SUB, OP_ADD, OP_SUB, OP_SUB, OP_ADD};
  int        tbl_n    [NUM_TESTS] = '{4, 4, 1, 1, 3, 2};
  int        tbl_w    [NUM_TESTS] = '{`NTM_MAX_W, `NTM_MAX_W, 1, 1, 5, `NTM_MAX_W};
  bit        tbl_gaps [NUM_TESTS] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1};

  logic            CLK;
  logic            RST;
  logic            start;
  adder_op_t       write_op;
  logic [SB-1:0]   size_n_in;
  logic [SB-1:0]   size_w_in;
  logic            a_in_enable;
  logic            w_in_enable;
  logic            m_in_enable;
  logic [DS-1:0]   a_in;
  logic [DS-1:0]   w_in;
  logic [DS-1:0]   m_in;
  logic            m_out_enable;
  logic [DS-1:0]   m_out;
  logic            ready;

  logic [31:0] lcg_state   = 32'h590e2894;
  int          cycle_cnt   = 0;
  int          cycle_limit = 0;

  ntm_clock_gen clock_gen (.CLK(CLK), .RST(RST));

  ntm_writing DUT (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .write_op    (write_op),
    .size_n_in   (size_n_in),
    .size_w_in   (size_w_in),
    .a_in_enable (a_in_enable),
    .w_in_enable (w_in_enable),
    .m_in_enable (m_in_enable),
    .a_in        (a_in),
    .w_in        (w_in),
    .m_in        (m_in),
    .m_out_enable(m_out_enable),
    .m_out       (m_out),
    .ready       (ready)
  );

  ntm_writing_checker writing_check (
    .CLK         (CLK),
    .RST         (RST),
    .m_out_enable(m_out_enable),
    .m_out       (m_out),
    .ready       (ready)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // LCG step, upper half as data
  function automatic logic [DS-1:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  // Twice the nominal length of every run
  function automatic int timeout_cycles();
    int total;
    total = 0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      total += tbl_w[i] + tbl_n[i] * (tbl_w[i] + 1) + 10;
    end
    return 2 * total;
  endfunction

  // Next falling edge, all strobes low
  task automatic next_cycle();
    @(negedge CLK);
    start       = 1'b0;
    a_in_enable = 1'b0;
    w_in_enable = 1'b0;
    m_in_enable = 1'b0;
  endtask

  // Random idle cycle before a strobe
  task automatic maybe_gap(input bit gaps);
    logic [DS-1:0] r;
    r = next_random();
    if (gaps && r[0]) begin
      next_cycle();
    end
  endtask

  task automatic run_test(input int t);
    logic [DS-1:0] a_vals [`NTM_MAX_W];
    logic [DS-1:0] w_val;
    logic [DS-1:0] m_val;
    // Stray strobes while idle, no output allowed
    next_cycle();
    m_in_enable = 1'b1;
    m_in        = next_random();
    w_in_enable = 1'b1;
    w_in        = next_random();
    next_cycle();
    m_in_enable = 1'b1;
    m_in        = next_random();
    next_cycle();
    next_cycle();
    // Start pulse with run sizes
    next_cycle();
    start     = 1'b1;
    write_op  = tbl_op[t];
    size_n_in = SB'(tbl_n[t]);
    size_w_in = SB'(tbl_w[t]);
    // Write vector
    for (int k = 0; k < tbl_w[t]; k++) begin
      maybe_gap(tbl_gaps[t]);
      a_vals[k] = next_random();
      next_cycle();
      a_in_enable = 1'b1;
      a_in        = a_vals[k];
    end
    // One weight, then a row of memory elements
    for (int j = 0; j < tbl_n[t]; j++) begin
      maybe_gap(tbl_gaps[t]);
      w_val = next_random();
      next_cycle();
      w_in_enable = 1'b1;
      w_in        = w_val;
      for (int k = 0; k < tbl_w[t]; k++) begin
        maybe_gap(tbl_gaps[t]);
        m_val = next_random();
        next_cycle();
        m_in_enable = 1'b1;
        m_in        = m_val;
        writing_check.expect_element(tbl_op[t], m_val, w_val, a_vals[k]);
      end
    end
    next_cycle();
    // Done pulse, bounded by the cycle counter
    while (ready !== 1'b1) begin
      next_cycle();
    end
    // Let the checker see ready and anything after it
    next_cycle();
    next_cycle();
    writing_check.end_test(t, tbl_n[t], tbl_w[t]);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    start       = 1'b0;
    write_op    = OP_ADD;
    size_n_in   = '0;
    size_w_in   = '0;
    a_in_enable = 1'b0;
    w_in_enable = 1'b0;
    m_in_enable = 1'b0;
    a_in        = '0;
    w_in        = '0;
    m_in        = '0;
    cycle_limit = timeout_cycles();
    @(posedge RST);
    @(negedge RST);
    next_cycle();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Tests passed %0d, failed %0d", writing_check.tests_passed,
             writing_check.tests_failed);
    if (writing_check.tests_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Run limit
  always @(posedge CLK) begin
    write_state_t st;
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      st = DUT.state;
      $display("Run stopped after %0d cycles, DUT stuck in state %s", cycle_cnt, st.name());
      $display("Something failed");
      $finish;
    end
  end

endmodule

`default_nettype wire
